// ==== logic/payload_fifo.sv ====
/*
 * Payload FIFO
 * synchronous buffer of stream beats, valid/ready on both ends
 */

`timescale 1ns/1ps
`default_nettype none

module payload_fifo import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  payload_beat_t in_beat,
    input  logic          in_valid,
    output logic          in_ready,
    output payload_beat_t out_beat,
    output logic          out_valid,
    input  logic          out_ready
);

    payload_beat_t         mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  wr_en;
    logic                  rd_en;

    assign in_ready  = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/udp_echo_pkg.sv ====
/*
 * UDP echo core shared definitions
 * widths, echo constants, header and payload structs, filter states
 */

`default_nettype none

package udp_echo_pkg;

    // payload stream widths
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // payload buffer sizing, depth must be a power of two
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

    // echo service configuration
    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [7:0]  REPLY_TTL = 8'd64;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // request header as handed over by the UDP stack
    typedef struct packed {
        ip_addr_t  source_ip;
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        logic [15:0] length;
    } udp_rx_hdr_t;

    // reply header towards the UDP stack
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [7:0]  ttl;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_tx_hdr_t;

    // one beat of the payload stream
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              user;
    } payload_beat_t;

    typedef enum logic [1:0] {
        FILT_IDLE,
        FILT_FORWARD,
        FILT_DISCARD
    } filter_state_t;

endpackage

`default_nettype wire

// ==== logic/udp_echo_top.sv ====
/*
 * UDP echo core
 * filter, payload buffer and reply generator in a chain
 */

`timescale 1ns/1ps
`default_nettype none

module udp_echo_top import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  udp_rx_hdr_t   rx_hdr,
    input  logic          rx_hdr_valid,
    output logic          rx_hdr_ready,
    input  payload_beat_t rx_beat,
    input  logic          rx_beat_valid,
    output logic          rx_beat_ready,
    output udp_tx_hdr_t   tx_hdr,
    output logic          tx_hdr_valid,
    input  logic          tx_hdr_ready,
    output payload_beat_t tx_beat,
    output logic          tx_beat_valid,
    input  logic          tx_beat_ready,
    output logic [1:0]    led
);

    udp_rx_hdr_t   fwd_hdr;
    logic          fwd_hdr_valid;
    logic          fwd_hdr_ready;
    payload_beat_t fwd_beat;
    logic          fwd_beat_valid;
    logic          fwd_beat_ready;
    payload_beat_t buf_beat;
    logic          buf_valid;
    logic          buf_ready;

    udp_port_filter filter_inst (
        .clk(clk),
        .rst(rst),
        .rx_hdr(rx_hdr),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_beat(rx_beat),
        .rx_beat_valid(rx_beat_valid),
        .rx_beat_ready(rx_beat_ready),
        .fwd_hdr(fwd_hdr),
        .fwd_hdr_valid(fwd_hdr_valid),
        .fwd_hdr_ready(fwd_hdr_ready),
        .fwd_beat(fwd_beat),
        .fwd_beat_valid(fwd_beat_valid),
        .fwd_beat_ready(fwd_beat_ready)
    );

    payload_fifo fifo_inst (
        .clk(clk),
        .rst(rst),
        .in_beat(fwd_beat),
        .in_valid(fwd_beat_valid),
        .in_ready(fwd_beat_ready),
        .out_beat(buf_beat),
        .out_valid(buf_valid),
        .out_ready(buf_ready)
    );

    udp_reply_gen reply_inst (
        .clk(clk),
        .rst(rst),
        .fwd_hdr(fwd_hdr),
        .fwd_hdr_valid(fwd_hdr_valid),
        .fwd_hdr_ready(fwd_hdr_ready),
        .buf_beat(buf_beat),
        .buf_valid(buf_valid),
        .buf_ready(buf_ready),
        .tx_hdr(tx_hdr),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_beat(tx_beat),
        .tx_beat_valid(tx_beat_valid),
        .tx_beat_ready(tx_beat_ready),
        .led(led)
    );

endmodule

`default_nettype wire

// ==== logic/udp_port_filter.sv ====
/*
 * UDP port filter
 * passes frames for the echo port on, drops everything else
 */

`timescale 1ns/1ps
`default_nettype none

module udp_port_filter import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  udp_rx_hdr_t   rx_hdr,
    input  logic          rx_hdr_valid,
    output logic          rx_hdr_ready,
    input  payload_beat_t rx_beat,
    input  logic          rx_beat_valid,
    output logic          rx_beat_ready,
    output udp_rx_hdr_t   fwd_hdr,
    output logic          fwd_hdr_valid,
    input  logic          fwd_hdr_ready,
    output payload_beat_t fwd_beat,
    output logic          fwd_beat_valid,
    input  logic          fwd_beat_ready
);

    filter_state_t state;
    logic          port_match;
    logic          hdr_accept;
    logic          last_accept;

    assign port_match = (rx_hdr.dest_port == ECHO_PORT);

    // header side, a header is only taken between frames
    assign fwd_hdr       = rx_hdr;
    assign fwd_hdr_valid = (state == FILT_IDLE) && rx_hdr_valid && port_match;
    assign rx_hdr_ready  = (state == FILT_IDLE) && (fwd_hdr_ready || !port_match);

    // payload side
    assign fwd_beat       = rx_beat;
    assign fwd_beat_valid = (state == FILT_FORWARD) && rx_beat_valid;

    always_comb begin
        case (state)
            FILT_FORWARD: rx_beat_ready = fwd_beat_ready;
            // dropped beats are swallowed at full rate
            FILT_DISCARD: rx_beat_ready = 1'b1;
            default:      rx_beat_ready = 1'b0;
        endcase
    end

    assign hdr_accept  = rx_hdr_valid && rx_hdr_ready;
    assign last_accept = rx_beat_valid && rx_beat_ready && rx_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILT_IDLE;
        end else begin
            case (state)
                FILT_IDLE: begin
                    if (hdr_accept) begin
                        state <= port_match ? FILT_FORWARD : FILT_DISCARD;
                    end
                end
                default: begin
                    if (last_accept) begin
                        state <= FILT_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/udp_reply_gen.sv ====
/*
 * UDP reply generator
 * registers the reply header, forwards buffered payload, drives the LEDs
 */

`timescale 1ns/1ps
`default_nettype none

module udp_reply_gen import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  udp_rx_hdr_t   fwd_hdr,
    input  logic          fwd_hdr_valid,
    output logic          fwd_hdr_ready,
    input  payload_beat_t buf_beat,
    input  logic          buf_valid,
    output logic          buf_ready,
    output udp_tx_hdr_t   tx_hdr,
    output logic          tx_hdr_valid,
    input  logic          tx_hdr_ready,
    output payload_beat_t tx_beat,
    output logic          tx_beat_valid,
    input  logic          tx_beat_ready,
    output logic [1:0]    led
);

    udp_tx_hdr_t reply_hdr;
    udp_tx_hdr_t hdr_reg;
    logic        hdr_valid_reg;
    logic        frame_start;
    logic        beat_xfer;

    // reply goes back to the requester with ports swapped
    always_comb begin
        reply_hdr.dscp        = 6'd0;
        reply_hdr.ecn         = 2'd0;
        reply_hdr.ttl         = REPLY_TTL;
        reply_hdr.source_ip   = LOCAL_IP;
        reply_hdr.dest_ip     = fwd_hdr.source_ip;
        reply_hdr.source_port = fwd_hdr.dest_port;
        reply_hdr.dest_port   = fwd_hdr.source_port;
        reply_hdr.length      = fwd_hdr.length;
        reply_hdr.checksum    = 16'd0;
    end

    // one-entry header slot, refilled in the cycle it drains
    assign fwd_hdr_ready = !hdr_valid_reg || tx_hdr_ready;
    assign tx_hdr        = hdr_reg;
    assign tx_hdr_valid  = hdr_valid_reg;

    always_ff @(posedge clk) begin
        if (fwd_hdr_valid && fwd_hdr_ready) begin
            hdr_reg <= reply_hdr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid_reg <= 1'b0;
        end else if (fwd_hdr_valid && fwd_hdr_ready) begin
            hdr_valid_reg <= 1'b1;
        end else if (tx_hdr_ready) begin
            hdr_valid_reg <= 1'b0;
        end
    end

    // payload straight through from the buffer
    assign tx_beat       = buf_beat;
    assign tx_beat_valid = buf_valid;
    assign buf_ready     = tx_beat_ready;
    assign beat_xfer     = tx_beat_valid && tx_beat_ready;

    // first beat of a frame is the one after a last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_start <= 1'b1;
            led         <= 2'b00;
        end else if (beat_xfer) begin
            frame_start <= tx_beat.last;
            if (frame_start) begin
                led <= tx_beat.data[1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the UDP echo testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f udp_echo.f --top-module udp_echo_tb -Mdir "$BUILD_DIR"

status=0
"./$BUILD_DIR/Vudp_echo_tb" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG" || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== testbench/tb_clock_gen.sv ====
/*
 * Testbench clock source
 * free-running 100 ns clock
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

`default_nettype wire

// ==== testbench/udp_echo_checker.sv ====
/*
 * UDP echo handshake checker
 * reset behavior and valid/ready hold rules on the tx side
 */

`timescale 1ns/1ps
`default_nettype none

module udp_echo_checker import udp_echo_pkg::*; (
    input logic          clk,
    input logic          rst,
    input udp_tx_hdr_t   tx_hdr,
    input logic          tx_hdr_valid,
    input logic          tx_hdr_ready,
    input payload_beat_t tx_beat,
    input logic          tx_beat_valid,
    input logic          tx_beat_ready
);

    // one reset cycle is enough to clear both output streams
    reset_quiet: assert property (@(posedge clk) rst |=> (!tx_hdr_valid && !tx_beat_valid))
        else $error("tx valid high while in reset");

    // a stalled header stays offered and unchanged
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=> (tx_hdr_valid && $stable(tx_hdr)))
        else $error("tx header dropped or changed while stalled");

    // same rule for payload beats
    beat_hold: assert property (@(posedge clk) disable iff (rst)
        (tx_beat_valid && !tx_beat_ready) |=> (tx_beat_valid && $stable(tx_beat)))
        else $error("tx beat dropped or changed while stalled");

endmodule

bind udp_echo_top udp_echo_checker handshake_checker (
    .clk(clk), .rst(rst),
    .tx_hdr(tx_hdr), .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
    .tx_beat(tx_beat), .tx_beat_valid(tx_beat_valid), .tx_beat_ready(tx_beat_ready)
);

`default_nettype wire

// ==== testbench/udp_echo_tb.sv ====
/*
 * UDP echo core testbench
 * random echo and non-echo frames, replies checked against a reference model
 */

`timescale 1ns/1ps
`default_nettype none

module udp_echo_tb import udp_echo_pkg::*; ();

    localparam int WAIT_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 20000;

    logic          clk;
    logic          rst;
    udp_rx_hdr_t   rx_hdr;
    logic          rx_hdr_valid;
    logic          rx_hdr_ready;
    payload_beat_t rx_beat;
    logic          rx_beat_valid;
    logic          rx_beat_ready;
    udp_tx_hdr_t   tx_hdr;
    logic          tx_hdr_valid;
    logic          tx_hdr_ready = 1'b0;
    payload_beat_t tx_beat;
    logic          tx_beat_valid;
    logic          tx_beat_ready = 1'b0;
    logic [1:0]    led;

    udp_tx_hdr_t   exp_hdr_q[$];
    payload_beat_t exp_beat_q[$];
    payload_beat_t exp_beat;
    string         test_name = "reset";
    int unsigned   hdr_pct = 100;
    int unsigned   beat_pct = 100;
    int            stall_cycles = 0;
    int            stall_before;
    logic          first_beat = 1'b1;
    logic          led_pending = 1'b0;
    logic [1:0]    led_exp = 2'b00;

    tb_clock_gen clock_inst (.clk(clk));

    udp_echo_top UUT (
        .clk(clk), .rst(rst),
        .rx_hdr(rx_hdr), .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready),
        .rx_beat(rx_beat), .rx_beat_valid(rx_beat_valid), .rx_beat_ready(rx_beat_ready),
        .tx_hdr(tx_hdr), .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
        .tx_beat(tx_beat), .tx_beat_valid(tx_beat_valid), .tx_beat_ready(tx_beat_ready),
        .led(led)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_hdr(input string name, input udp_tx_hdr_t exp, input udp_tx_hdr_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_beat(input string name, input payload_beat_t exp,
                              input payload_beat_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_led(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    // reply back to the sender, ports swapped, fixed IP fields
    function automatic udp_tx_hdr_t expected_reply(input udp_rx_hdr_t req);
        udp_tx_hdr_t rep;
        rep.dscp        = 6'd0;
        rep.ecn         = 2'd0;
        rep.ttl         = 8'd64;
        rep.source_ip   = {8'd192, 8'd168, 8'd1, 8'd128};
        rep.dest_ip     = req.source_ip;
        rep.source_port = req.dest_port;
        rep.dest_port   = req.source_port;
        rep.length      = req.length;
        rep.checksum    = 16'd0;
        return rep;
    endfunction

    task automatic send_hdr(input udp_rx_hdr_t hdr);
        int waited;
        waited = 0;
        rx_hdr = hdr;
        rx_hdr_valid = 1'b1;
        @(negedge clk);
        while (!rx_hdr_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run({test_name, ": request header was never accepted"});
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input payload_beat_t beat);
        int waited;
        waited = 0;
        rx_beat = beat;
        rx_beat_valid = 1'b1;
        @(negedge clk);
        while (!rx_beat_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run({test_name, ": request payload beat was never accepted"});
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        rx_beat_valid = 1'b0;
    endtask

    // expected results are queued before the request goes in
    task automatic send_frame(input bit echo);
        udp_rx_hdr_t   hdr;
        payload_beat_t beat;
        int            n_beats;
        n_beats = $urandom_range(6, 1);
        hdr.source_ip   = $urandom;
        hdr.dest_ip     = LOCAL_IP;
        hdr.source_port = 16'($urandom_range(65535, 1024));
        hdr.dest_port   = echo ? ECHO_PORT : 16'($urandom);
        if (!echo && hdr.dest_port == ECHO_PORT) begin
            hdr.dest_port = ECHO_PORT + 16'd1;
        end
        hdr.length = 16'(8 + 8 * n_beats);
        if (echo) begin
            exp_hdr_q.push_back(expected_reply(hdr));
        end
        send_hdr(hdr);
        for (int i = 0; i < n_beats; i++) begin
            beat.data = {$urandom, $urandom};
            beat.keep = (i == n_beats - 1) ? 8'($urandom_range(255, 1)) : 8'hff;
            beat.last = (i == n_beats - 1);
            beat.user = 1'($urandom);
            if (echo) begin
                exp_beat_q.push_back(beat);
            end
            send_beat(beat);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                fail_run({test_name, ": expected replies never came out"});
            end
        end
        // room for any stray output to show up
        repeat (8) @(posedge clk);
        #1;
    endtask

    // tx ready patterns
    always @(posedge clk) begin
        #1;
        tx_hdr_ready = ($urandom_range(99, 0) < hdr_pct);
        tx_beat_ready = ($urandom_range(99, 0) < beat_pct);
    end

    // compare process, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (led_pending) begin
                check_led({test_name, " led"}, led_exp, led);
                led_pending = 1'b0;
            end
            if (rx_beat_valid && !rx_beat_ready) begin
                stall_cycles++;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    fail_run({test_name, ": reply header sent when none was expected"});
                end
                check_hdr({test_name, " header"}, exp_hdr_q.pop_front(), tx_hdr);
            end
            if (tx_beat_valid && tx_beat_ready) begin
                if (exp_beat_q.size() == 0) begin
                    fail_run({test_name, ": payload beat sent when none was expected"});
                end
                exp_beat = exp_beat_q.pop_front();
                check_beat({test_name, " beat"}, exp_beat, tx_beat);
                if (first_beat) begin
                    led_exp = exp_beat.data[1:0];
                    led_pending = 1'b1;
                end
                first_beat = exp_beat.last;
            end
        end
    end

    initial begin
        void'($urandom(90));
        rst = 1'b1;
        rx_hdr = '0;
        rx_hdr_valid = 1'b0;
        rx_beat = '0;
        rx_beat_valid = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        if (tx_hdr_valid || tx_beat_valid) begin
            fail_run("tx valid is high right after reset");
        end
        check_led("reset led", 2'b00, led);

        test_name = "single echo";
        send_frame(1'b1);
        drain();

        test_name = "discard then echo";
        send_frame(1'b0);
        send_frame(1'b1);
        drain();

        test_name = "random mix";
        hdr_pct = 60;
        beat_pct = 60;
        for (int i = 0; i < 40; i++) begin
            send_frame($urandom_range(1, 0) == 1);
        end
        drain();

        // slow tx side so the payload buffer backs up
        test_name = "fifo fill";
        hdr_pct = 50;
        beat_pct = 5;
        stall_before = stall_cycles;
        for (int i = 0; i < 24; i++) begin
            send_frame($urandom_range(3, 0) != 0);
        end
        drain();
        if (stall_cycles == stall_before) begin
            fail_run("payload FIFO never filled up during the fill test");
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== udp_echo.f ====
logic/udp_echo_pkg.sv
logic/udp_port_filter.sv
logic/payload_fifo.sv
logic/udp_reply_gen.sv
logic/udp_echo_top.sv
testbench/tb_clock_gen.sv
testbench/udp_echo_checker.sv
testbench/udp_echo_tb.sv
